// ==== source/radio_ctrl_macros.svh ====
// Radio control constants
// Hold-off length, register map, SPI divider default
`ifndef RADIO_CTRL_MACROS_SVH
`define RADIO_CTRL_MACROS_SVH

// Hold-off counter width, release after 2**N bus clocks
`define RC_HOLDOFF_BITS 16

// Settings register map
`define RC_ADDR_MISC    8'd0  // Band selects, ref_sel, mimo, codec reset, ATR swap
`define RC_ADDR_ATR0    8'd1  // Radio 0 frontend ATR word
`define RC_ADDR_ATR1    8'd2  // Radio 1 frontend ATR word
`define RC_ADDR_SPI_DIV 8'd3  // Half SCLK period minus one, in bus clocks
`define RC_ADDR_STATUS  8'd4  // Read only, {spi_busy, pll_locked}

// Slow enough for both slaves out of reset
`define RC_SPI_DIV_RESET 32'd15

`endif

// ==== source/radio_ctrl_pkg.sv ====
// Control word views, decoded command structs, response word
package radio_ctrl_pkg;

   typedef enum logic [1:0] {
      OP_WRITE = 2'd1,  // Settings register write
      OP_READ  = 2'd2,  // Register readback
      OP_SPI   = 2'd3   // Peripheral SPI transfer
   } ctrl_op_e;

   // Register access view
   typedef struct packed {
      ctrl_op_e    op;
      logic [21:0] rsvd;
      logic [7:0]  addr;
      logic [31:0] data;
   } ctrl_reg_view_t;

   // SPI transfer view, same opcode position
   typedef struct packed {
      ctrl_op_e    op;
      logic [20:0] rsvd;
      logic [2:0]  slave;
      logic [5:0]  nbits;    // 1 to 32, zero means 32
      logic [31:0] payload;  // Right-aligned
   } ctrl_spi_view_t;

   typedef union packed {
      ctrl_reg_view_t reg_v;
      ctrl_spi_view_t spi_v;
   } ctrl_word_u;

   typedef struct packed {
      logic        wr;
      logic        rd;
      logic [7:0]  addr;
      logic [31:0] data;
   } set_cmd_t;

   typedef struct packed {
      logic        start;
      logic [2:0]  slave;
      logic [5:0]  nbits;
      logic [31:0] payload;
   } spi_cmd_t;

   typedef struct packed {
      ctrl_op_e    kind;  // OP_READ or OP_SPI
      logic [21:0] rsvd;
      logic [7:0]  tag;   // Register address or slave index
      logic [31:0] data;
   } resp_t;

endpackage

// ==== source/clocks_ready_holdoff.sv ====
// Clocks-ready hold-off
// Internal reset held until lock plus 2**RC_HOLDOFF_BITS cycles
`timescale 1ns/10ps
`include "radio_ctrl_macros.svh"

module clocks_ready_holdoff (
   input  logic bus_clk,
   input  logic reset_global,
   input  logic pll_locked,
   output logic core_reset
);

   logic [`RC_HOLDOFF_BITS-1:0] count;
   logic                        ready;

   always_ff @(posedge bus_clk or posedge reset_global) begin
      if (reset_global) begin
         count <= '0;
         ready <= 1'b0;
      end else if (!pll_locked) begin  // Lost lock, start over
         count <= '0;
         ready <= 1'b0;
      end else if (!ready) begin  // Stops once released
         count <= count + 1'b1;
         ready <= &count;
      end
   end

   assign core_reset = ~ready;

endmodule

// ==== source/ctrl_word_decode.sv ====
// Control word decoder
// Registers one host word, splits it into settings or SPI strobes
`timescale 1ns/10ps

module ctrl_word_decode (
   input  logic                       bus_clk,
   input  logic                       reset_global,
   input  logic                       ctrl_valid,
   input  radio_ctrl_pkg::ctrl_word_u ctrl_word,
   output radio_ctrl_pkg::set_cmd_t   set_cmd,
   output radio_ctrl_pkg::spi_cmd_t   spi_cmd
);

   logic                       word_vld;  // One cycle behind ctrl_valid
   radio_ctrl_pkg::ctrl_word_u word_r;
   logic [5:0]                 nbits_raw;

   always_ff @(posedge bus_clk or posedge reset_global) begin
      if (reset_global) begin
         word_vld <= 1'b0;
      end else begin
         word_vld <= ctrl_valid;
      end
   end

   always_ff @(posedge bus_clk) begin
      if (ctrl_valid) begin
         word_r <= ctrl_word;
      end
   end

   // Opcode picks the view, at most one strobe fires
   always_comb begin
      nbits_raw     = word_r.spi_v.nbits;
      set_cmd.wr    = word_vld && (word_r.reg_v.op == radio_ctrl_pkg::OP_WRITE);
      set_cmd.rd    = word_vld && (word_r.reg_v.op == radio_ctrl_pkg::OP_READ);
      set_cmd.addr  = word_r.reg_v.addr;
      set_cmd.data  = word_r.reg_v.data;
      spi_cmd.start = word_vld && (word_r.spi_v.op == radio_ctrl_pkg::OP_SPI);
      spi_cmd.slave = word_r.spi_v.slave;
      // Zero or out of range means a full word
      spi_cmd.nbits = (nbits_raw == 6'd0 || nbits_raw > 6'd32) ? 6'd32 : nbits_raw;
      spi_cmd.payload = word_r.spi_v.payload;
   end

endmodule

// ==== source/settings_regs.sv ====
// Settings register bank
// Misc outputs, both ATR words, SPI divider, readback mux
`timescale 1ns/10ps
`include "radio_ctrl_macros.svh"

module settings_regs (
   input  logic                     bus_clk,
   input  logic                     reset_global,
   input  radio_ctrl_pkg::set_cmd_t set_cmd,
   input  logic                     spi_busy,
   input  logic                     pll_locked,
   output logic [31:0]              misc_outs,
   output logic [31:0]              fe_atr0,
   output logic [31:0]              fe_atr1,
   output logic [31:0]              spi_div,
   output logic                     rb_valid,
   output logic [7:0]               rb_addr,
   output logic [31:0]              rb_data
);

   ////////////////////////////////////////////////////////////////////////////
   // Writable registers
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge bus_clk or posedge reset_global) begin
      if (reset_global) begin
         misc_outs <= 32'd0;
         fe_atr0   <= 32'd0;
         fe_atr1   <= 32'd0;
         spi_div   <= `RC_SPI_DIV_RESET;
      end else if (set_cmd.wr) begin
         case (set_cmd.addr)
            `RC_ADDR_MISC:    misc_outs <= set_cmd.data;
            `RC_ADDR_ATR0:    fe_atr0   <= set_cmd.data;
            `RC_ADDR_ATR1:    fe_atr1   <= set_cmd.data;
            `RC_ADDR_SPI_DIV: spi_div   <= set_cmd.data;
            default: ;  // Status and holes are read only
         endcase
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Readback, registered once in the response block
   ////////////////////////////////////////////////////////////////////////////
   assign rb_valid = set_cmd.rd;
   assign rb_addr  = set_cmd.addr;

   always_comb begin
      case (set_cmd.addr)
         `RC_ADDR_MISC:    rb_data = misc_outs;
         `RC_ADDR_ATR0:    rb_data = fe_atr0;
         `RC_ADDR_ATR1:    rb_data = fe_atr1;
         `RC_ADDR_SPI_DIV: rb_data = spi_div;
         `RC_ADDR_STATUS:  rb_data = {30'd0, spi_busy, pll_locked};
         default:          rb_data = 32'd0;  // Unmapped
      endcase
   end

endmodule

// ==== source/spi_shift_engine.sv ====
// SPI mode-0 master
// MSB first out on mosi, right-aligned capture from miso
`timescale 1ns/10ps

module spi_shift_engine (
   input  logic                     bus_clk,
   input  logic                     reset_global,
   input  radio_ctrl_pkg::spi_cmd_t spi_cmd,
   input  logic [31:0]              spi_div,
   input  logic                     miso,
   output logic                     sclk,
   output logic                     mosi,
   output logic [7:0]               sen,      // Active low, one per slave
   output logic                     spi_busy,
   output logic                     spi_done,
   output logic [2:0]               spi_slave,
   output logic [31:0]              spi_rdata
);

   logic [31:0] div_cnt;    // Cycles into the current half period
   logic [5:0]  bits_left;
   logic [31:0] shift_out;  // Payload MSB-aligned
   logic [31:0] shift_in;
   logic        tick;       // Half period done

   assign tick      = (div_cnt == spi_div);
   assign mosi      = shift_out[31];
   assign spi_rdata = shift_in;

   ////////////////////////////////////////////////////////////////////////////
   // Sequencing
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge bus_clk or posedge reset_global) begin
      if (reset_global) begin
         spi_busy  <= 1'b0;
         spi_done  <= 1'b0;
         sclk      <= 1'b0;
         sen       <= 8'hff;
         div_cnt   <= 32'd0;
         bits_left <= 6'd0;
      end else begin
         spi_done <= 1'b0;
         if (!spi_busy) begin
            div_cnt <= 32'd0;
            if (spi_cmd.start) begin  // Start only when idle
               spi_busy  <= 1'b1;
               sen       <= ~(8'd1 << spi_cmd.slave);
               bits_left <= spi_cmd.nbits;
            end
         end else if (tick) begin
            div_cnt <= 32'd0;
            sclk    <= ~sclk;
            if (sclk) begin  // Falling edge closes a bit
               bits_left <= bits_left - 6'd1;
               if (bits_left == 6'd1) begin
                  spi_busy <= 1'b0;
                  spi_done <= 1'b1;
                  sen      <= 8'hff;
               end
            end
         end else begin
            div_cnt <= div_cnt + 32'd1;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Shift registers
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge bus_clk) begin
      if (!spi_busy && spi_cmd.start) begin
         shift_out <= spi_cmd.payload << (6'd32 - spi_cmd.nbits);
         shift_in  <= 32'd0;
         spi_slave <= spi_cmd.slave;
      end else if (spi_busy && tick) begin
         if (!sclk) begin
            shift_in <= {shift_in[30:0], miso};  // Sample on rise
         end else begin
            shift_out <= {shift_out[30:0], 1'b0};  // Launch next on fall
         end
      end
   end

endmodule

// ==== source/frontend_pin_map.sv ====
// Frontend pin mapping
// ATR swap, registered misc pins, per-slave SPI gating
`timescale 1ns/10ps

module frontend_pin_map (
   input  logic        bus_clk,
   input  logic        reset_global,
   input  logic [31:0] misc_outs,
   input  logic [31:0] fe_atr0,
   input  logic [31:0] fe_atr1,
   input  logic        sclk,
   input  logic        mosi,
   input  logic [7:0]  sen,
   input  logic        cat_miso,
   output logic        miso,
   output logic        cat_ce,
   output logic        cat_mosi,
   output logic        cat_sclk,
   output logic        pll_ce,
   output logic        pll_mosi,
   output logic        pll_sclk,
   output logic [7:0]  atr_fe1,
   output logic [7:0]  atr_fe2,
   output logic        swap_atr_n,
   output logic        tx_bandsel_a,
   output logic        tx_bandsel_b,
   output logic        rx_bandsel_a,
   output logic        rx_bandsel_b,
   output logic        rx_bandsel_c,
   output logic        codec_arst,
   output logic        mimo,
   output logic        ref_sel
);

   logic [8:0] misc_r;  // Flop near the pins

   always_ff @(posedge bus_clk or posedge reset_global) begin
      if (reset_global) misc_r <= 9'd0;
      else              misc_r <= misc_outs[8:0];
   end

   assign {swap_atr_n, tx_bandsel_a, tx_bandsel_b, rx_bandsel_a, rx_bandsel_b,
           rx_bandsel_c, codec_arst, mimo, ref_sel} = misc_r;

   // Radio to frontend, swapped on most boards
   assign atr_fe1 = swap_atr_n ? fe_atr1[7:0] : fe_atr0[7:0];
   assign atr_fe2 = swap_atr_n ? fe_atr0[7:0] : fe_atr1[7:0];

   // Codec on slave 0
   assign cat_ce   = sen[0];
   assign cat_mosi = ~sen[0] & mosi;
   assign cat_sclk = ~sen[0] & sclk;
   assign miso     = cat_miso;  // PLL has no miso

   // PLL on slave 1
   assign pll_ce   = sen[1];
   assign pll_mosi = ~sen[1] & mosi;
   assign pll_sclk = ~sen[1] & sclk;

endmodule

// ==== source/ctrl_response.sv ====
// Response word builder
// Readbacks first, SPI result held one cycle on collision
`timescale 1ns/10ps

module ctrl_response (
   input  logic                  bus_clk,
   input  logic                  reset_global,
   input  logic                  rb_valid,
   input  logic [7:0]            rb_addr,
   input  logic [31:0]           rb_data,
   input  logic                  spi_done,
   input  logic [2:0]            spi_slave,
   input  logic [31:0]           spi_rdata,
   output logic                  resp_valid,
   output radio_ctrl_pkg::resp_t resp_word
);

   radio_ctrl_pkg::resp_t rb_resp;
   radio_ctrl_pkg::resp_t spi_resp;
   radio_ctrl_pkg::resp_t pend_resp;  // SPI result waiting behind a readback
   logic                  pend_vld;

   always_comb begin
      rb_resp       = '0;
      rb_resp.kind  = radio_ctrl_pkg::OP_READ;
      rb_resp.tag   = rb_addr;
      rb_resp.data  = rb_data;
      spi_resp      = '0;
      spi_resp.kind = radio_ctrl_pkg::OP_SPI;
      spi_resp.tag  = {5'd0, spi_slave};
      spi_resp.data = spi_rdata;
   end

   always_ff @(posedge bus_clk or posedge reset_global) begin
      if (reset_global) begin
         resp_valid <= 1'b0;
         pend_vld   <= 1'b0;
      end else begin
         resp_valid <= rb_valid | pend_vld | spi_done;
         pend_vld   <= rb_valid & (spi_done | pend_vld);  // Keep waiting while readbacks win
      end
   end

   always_ff @(posedge bus_clk) begin
      if (rb_valid)      resp_word <= rb_resp;
      else if (pend_vld) resp_word <= pend_resp;
      else if (spi_done) resp_word <= spi_resp;
      if (rb_valid && spi_done) pend_resp <= spi_resp;
   end

endmodule

// ==== source/radio_ctrl_top.sv ====
// Radio control subsystem top
// Hold-off, decode, settings, SPI engine, pin map, response
`timescale 1ns/10ps

module radio_ctrl_top (
   input  logic                       bus_clk,
   input  logic                       reset_global,
   input  logic                       pll_locked,
   input  logic                       ctrl_valid,
   input  radio_ctrl_pkg::ctrl_word_u ctrl_word,
   input  logic                       cat_miso,
   output logic                       cat_ce,
   output logic                       cat_mosi,
   output logic                       cat_sclk,
   output logic                       pll_ce,
   output logic                       pll_mosi,
   output logic                       pll_sclk,
   output logic [7:0]                 atr_fe1,
   output logic [7:0]                 atr_fe2,
   output logic                       swap_atr_n,
   output logic                       tx_bandsel_a,
   output logic                       tx_bandsel_b,
   output logic                       rx_bandsel_a,
   output logic                       rx_bandsel_b,
   output logic                       rx_bandsel_c,
   output logic                       codec_arst,
   output logic                       mimo,
   output logic                       ref_sel,
   output logic                       resp_valid,
   output radio_ctrl_pkg::resp_t      resp_word
);

   logic                     core_reset;  // Held until clocks settle
   radio_ctrl_pkg::set_cmd_t set_cmd;
   radio_ctrl_pkg::spi_cmd_t spi_cmd;
   logic [31:0]              misc_outs;
   logic [31:0]              fe_atr0;
   logic [31:0]              fe_atr1;
   logic [31:0]              spi_div;
   logic                     rb_valid;
   logic [7:0]               rb_addr;
   logic [31:0]              rb_data;
   logic                     sclk;
   logic                     mosi;
   logic                     miso;
   logic [7:0]               sen;
   logic                     spi_busy;
   logic                     spi_done;
   logic [2:0]               spi_slave;
   logic [31:0]              spi_rdata;

   clocks_ready_holdoff u_holdoff (
      .bus_clk(bus_clk), .reset_global(reset_global), .pll_locked(pll_locked),
      .core_reset(core_reset)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Decode and execute
   ////////////////////////////////////////////////////////////////////////////
   ctrl_word_decode u_decode (
      .bus_clk(bus_clk), .reset_global(core_reset),
      .ctrl_valid(ctrl_valid), .ctrl_word(ctrl_word),
      .set_cmd(set_cmd), .spi_cmd(spi_cmd)
   );

   settings_regs u_settings (
      .bus_clk(bus_clk), .reset_global(core_reset), .set_cmd(set_cmd),
      .spi_busy(spi_busy), .pll_locked(pll_locked),
      .misc_outs(misc_outs), .fe_atr0(fe_atr0), .fe_atr1(fe_atr1), .spi_div(spi_div),
      .rb_valid(rb_valid), .rb_addr(rb_addr), .rb_data(rb_data)
   );

   spi_shift_engine u_spi (
      .bus_clk(bus_clk), .reset_global(core_reset), .spi_cmd(spi_cmd),
      .spi_div(spi_div), .miso(miso),
      .sclk(sclk), .mosi(mosi), .sen(sen), .spi_busy(spi_busy),
      .spi_done(spi_done), .spi_slave(spi_slave), .spi_rdata(spi_rdata)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Pins and responses
   ////////////////////////////////////////////////////////////////////////////
   frontend_pin_map u_pins (
      .bus_clk(bus_clk), .reset_global(core_reset),
      .misc_outs(misc_outs), .fe_atr0(fe_atr0), .fe_atr1(fe_atr1),
      .sclk(sclk), .mosi(mosi), .sen(sen), .cat_miso(cat_miso), .miso(miso),
      .cat_ce(cat_ce), .cat_mosi(cat_mosi), .cat_sclk(cat_sclk),
      .pll_ce(pll_ce), .pll_mosi(pll_mosi), .pll_sclk(pll_sclk),
      .atr_fe1(atr_fe1), .atr_fe2(atr_fe2), .swap_atr_n(swap_atr_n),
      .tx_bandsel_a(tx_bandsel_a), .tx_bandsel_b(tx_bandsel_b),
      .rx_bandsel_a(rx_bandsel_a), .rx_bandsel_b(rx_bandsel_b),
      .rx_bandsel_c(rx_bandsel_c), .codec_arst(codec_arst),
      .mimo(mimo), .ref_sel(ref_sel)
   );

   ctrl_response u_resp (
      .bus_clk(bus_clk), .reset_global(core_reset),
      .rb_valid(rb_valid), .rb_addr(rb_addr), .rb_data(rb_data),
      .spi_done(spi_done), .spi_slave(spi_slave), .spi_rdata(spi_rdata),
      .resp_valid(resp_valid), .resp_word(resp_word)
   );

endmodule

// ==== tests/radio_ctrl_tests.svh ====
// Directed tests for the radio control subsystem
// Hold-off, readback, ATR swap, misc pins, codec SPI, random register writes
`ifndef RADIO_CTRL_TESTS_SVH
`define RADIO_CTRL_TESTS_SVH

task automatic holdoff_test();
   logic                  got;
   int                    waited;
   int                    polls;
   radio_ctrl_pkg::resp_t resp;
   start_test("holdoff");
   if (cat_ce !== 1'b1) report_mismatch("cat_ce", 32'd1, 32'(cat_ce));
   if (pll_ce !== 1'b1) report_mismatch("pll_ce", 32'd1, 32'(pll_ce));
   if (cat_sclk !== 1'b0) report_mismatch("cat_sclk", 32'd0, 32'(cat_sclk));
   if (atr_fe1 !== 8'd0) report_mismatch("atr_fe1", 32'd0, 32'(atr_fe1));
   if (atr_fe2 !== 8'd0) report_mismatch("atr_fe2", 32'd0, 32'(atr_fe2));
   if ({swap_atr_n, tx_bandsel_a, tx_bandsel_b, rx_bandsel_a, rx_bandsel_b,
        rx_bandsel_c, codec_arst, mimo, ref_sel} !== 9'd0)
      report_mismatch("misc pins", 32'd0,
                      32'({swap_atr_n, tx_bandsel_a, tx_bandsel_b, rx_bandsel_a,
                           rx_bandsel_b, rx_bandsel_c, codec_arst, mimo, ref_sel}));
   send_word(reg_word(radio_ctrl_pkg::OP_WRITE, `RC_ADDR_ATR0, 32'h5a5a_5a5a));  // Dropped
   for (int i = 0; i < 32; i++) begin
      next_cycle();
      if (resp_valid) report_mismatch("resp_valid during hold-off", 32'd0, 32'(resp_valid));
   end
   // Poll ATR0 until the core answers
   got   = 1'b0;
   polls = 0;
   while (!got && polls < HOLDOFF_CYCLES) begin
      send_word(reg_word(radio_ctrl_pkg::OP_READ, `RC_ADDR_ATR0, 32'd0));
      wait_response(4, got, waited, resp);
      polls++;
   end
   if (!got) begin
      report_error("core never left hold-off");
   end else begin
      if (cycle_count < HOLDOFF_CYCLES) report_error("hold-off released too early");
      if (resp.data !== 32'd0) report_mismatch("ATR0 after hold-off write", 32'd0, resp.data);
      read_expect(`RC_ADDR_SPI_DIV, `RC_SPI_DIV_RESET);
      read_expect(`RC_ADDR_MISC, 32'd0);
   end
   finish_test();
endtask

task automatic readback_test();
   logic [31:0] vals [0:3];
   start_test("readback");
   for (int i = 0; i < 4; i++) begin
      vals[i] = $urandom();
      write_reg(8'(i), vals[i]);
   end
   for (int i = 0; i < 4; i++) read_expect(8'(i), vals[i]);
   read_expect(`RC_ADDR_STATUS, 32'd1);  // pll_locked in bit 0
   finish_test();
endtask

task automatic atr_swap_test();
   logic [31:0] atr0;
   logic [31:0] atr1;
   start_test("atr_swap");
   atr0 = $urandom();
   atr1 = $urandom();
   write_reg(`RC_ADDR_ATR0, atr0);
   write_reg(`RC_ADDR_ATR1, atr1);
   write_reg(`RC_ADDR_MISC, 32'h0);
   repeat (3) next_cycle();
   if (atr_fe1 !== atr0[7:0]) report_mismatch("atr_fe1 straight", 32'(atr0[7:0]), 32'(atr_fe1));
   if (atr_fe2 !== atr1[7:0]) report_mismatch("atr_fe2 straight", 32'(atr1[7:0]), 32'(atr_fe2));
   write_reg(`RC_ADDR_MISC, 32'h100);  // swap_atr_n high
   repeat (3) next_cycle();
   if (swap_atr_n !== 1'b1) report_mismatch("swap_atr_n", 32'd1, 32'(swap_atr_n));
   if (atr_fe1 !== atr1[7:0]) report_mismatch("atr_fe1 swapped", 32'(atr1[7:0]), 32'(atr_fe1));
   if (atr_fe2 !== atr0[7:0]) report_mismatch("atr_fe2 swapped", 32'(atr0[7:0]), 32'(atr_fe2));
   finish_test();
endtask

task automatic misc_field_test();
   logic [8:0] misc;
   start_test("misc_fields");
   misc = 9'($urandom());
   write_reg(`RC_ADDR_MISC, {23'd0, misc});
   repeat (3) next_cycle();  // Misc pins land three cycles after the strobe
   if (swap_atr_n !== misc[8]) report_mismatch("swap_atr_n", 32'(misc[8]), 32'(swap_atr_n));
   if (tx_bandsel_a !== misc[7]) report_mismatch("tx_bandsel_a", 32'(misc[7]), 32'(tx_bandsel_a));
   if (tx_bandsel_b !== misc[6]) report_mismatch("tx_bandsel_b", 32'(misc[6]), 32'(tx_bandsel_b));
   if (rx_bandsel_a !== misc[5]) report_mismatch("rx_bandsel_a", 32'(misc[5]), 32'(rx_bandsel_a));
   if (rx_bandsel_b !== misc[4]) report_mismatch("rx_bandsel_b", 32'(misc[4]), 32'(rx_bandsel_b));
   if (rx_bandsel_c !== misc[3]) report_mismatch("rx_bandsel_c", 32'(misc[3]), 32'(rx_bandsel_c));
   if (codec_arst !== misc[2]) report_mismatch("codec_arst", 32'(misc[2]), 32'(codec_arst));
   if (mimo !== misc[1]) report_mismatch("mimo", 32'(misc[1]), 32'(mimo));
   if (ref_sel !== misc[0]) report_mismatch("ref_sel", 32'(misc[0]), 32'(ref_sel));
   finish_test();
endtask

task automatic spi_transfer_test();
   logic [31:0] div;
   logic [31:0] payload;
   int          rise_start;
   int          reads_sent;
   int          reads_seen;
   int          spi_seen;
   int          ce_low;
   int          tail;
   int          cycles;
   logic        done;
   start_test("spi");
   div        = $urandom_range(SPI_DIV_MAX, 0);
   payload    = $urandom();
   reads_sent = 0;
   reads_seen = 0;
   spi_seen   = 0;
   ce_low     = 0;
   tail       = 4;  // Readbacks kept going past the end of the transfer
   cycles     = 0;
   done       = 1'b0;
   write_reg(`RC_ADDR_SPI_DIV, div);
   rise_start = rise_cnt;
   send_word(spi_word(3'd0, 6'd24, payload));
   // Back to back readbacks so one lands on the SPI completion
   while (!done && cycles < SPI_CYCLES) begin
      ctrl_word  = reg_word(radio_ctrl_pkg::OP_READ, `RC_ADDR_ATR0, 32'd0);
      ctrl_valid = (tail > 0);
      if (tail > 0) reads_sent++;
      next_cycle();
      cycles++;
      if ({pll_ce, pll_sclk, pll_mosi} !== 3'b100)
         report_mismatch("PLL SPI lines", 32'b100, 32'({pll_ce, pll_sclk, pll_mosi}));
      if (!cat_ce) ce_low++;
      else if (ce_low > 0 && tail > 0) tail--;
      if (resp_valid) begin
         if (resp_word.kind == radio_ctrl_pkg::OP_READ) begin
            reads_seen++;
            if (resp_word.data !== shadow[1])
               report_mismatch("readback during transfer", shadow[1], resp_word.data);
         end else if (resp_word.kind == radio_ctrl_pkg::OP_SPI) begin
            spi_seen++;
            if (reads_seen == 0) report_error("SPI response came before any readback");
            if (resp_word.tag !== 8'd0) report_mismatch("spi slave", 32'd0, 32'(resp_word.tag));
            if (resp_word.data !== {8'd0, MISO_PATTERN})
               report_mismatch("spi read data", {8'd0, MISO_PATTERN}, resp_word.data);
         end else begin
            report_error("response of unknown kind");
         end
      end
      done = (tail == 0) && (spi_seen > 0) && (reads_seen == reads_sent);
   end
   ctrl_valid = 1'b0;
   if (!done) report_error("SPI transfer or its readbacks never completed");
   if (spi_seen > 1) report_error("more than one SPI response");
   if (ce_low != 48 * (div + 1)) report_mismatch("cat_ce low cycles", 48 * (div + 1), ce_low);
   if (rise_cnt - rise_start != 24) report_mismatch("cat_sclk rises", 32'd24, rise_cnt - rise_start);
   if (mosi_rx[23:0] !== payload[23:0])
      report_mismatch("codec received bits", 32'(payload[23:0]), 32'(mosi_rx[23:0]));
   finish_test();
endtask

task automatic random_write_test();
   logic [7:0]  addr;
   logic [31:0] data;
   start_test("random_writes");
   for (int i = 0; i < 20; i++) begin
      addr = 8'($urandom_range(7, 0));  // Includes status and unmapped holes
      data = $urandom();
      write_reg(addr, data);
      read_expect(addr, expected_reg(addr));
   end
   for (int a = 0; a < 5; a++) read_expect(8'(a), expected_reg(8'(a)));
   finish_test();
endtask

`endif

// ==== tests/radio_ctrl_tb.sv ====
// Testbench top for the radio control subsystem
// Clock, reset, run limit, codec SPI slave model, helper tasks, run sequence
`timescale 1ns/10ps
`include "radio_ctrl_macros.svh"

module radio_ctrl_tb;

   ////////////////////////////////////////////////////////////////////////////
   // Run length
   ////////////////////////////////////////////////////////////////////////////
   localparam int HOLDOFF_CYCLES = 1 << `RC_HOLDOFF_BITS;
   localparam int SPI_DIV_MAX    = 7;                               // Random divider range
   localparam int SPI_CYCLES     = 24 * 2 * (SPI_DIV_MAX + 1) + 64; // One transfer plus tail
   localparam int REG_CYCLES     = 80 * 8;                          // Register accesses
   localparam int CYCLE_LIMIT    = 2 + 64 + HOLDOFF_CYCLES + SPI_CYCLES + REG_CYCLES;

   localparam logic [23:0] MISO_PATTERN = 24'hc3_5a_96;  // Codec answer

   logic                       bus_clk;
   logic                       reset_global;
   logic                       pll_locked;
   logic                       ctrl_valid;
   radio_ctrl_pkg::ctrl_word_u ctrl_word;
   logic                       cat_miso;
   logic                       cat_ce;
   logic                       cat_mosi;
   logic                       cat_sclk;
   logic                       pll_ce;
   logic                       pll_mosi;
   logic                       pll_sclk;
   logic [7:0]                 atr_fe1;
   logic [7:0]                 atr_fe2;
   logic                       swap_atr_n;
   logic                       tx_bandsel_a;
   logic                       tx_bandsel_b;
   logic                       rx_bandsel_a;
   logic                       rx_bandsel_b;
   logic                       rx_bandsel_c;
   logic                       codec_arst;
   logic                       mimo;
   logic                       ref_sel;
   logic                       resp_valid;
   radio_ctrl_pkg::resp_t      resp_word;

   int          cycle_count = 0;
   int          error_count = 0;
   int          test_count  = 0;
   int          test_start_errors;
   string       cur_test;
   logic [31:0] shadow [0:3];  // Writable registers as the host sees them

   // Codec model state
   int          fall_cnt = 0;
   int          rise_cnt = 0;
   logic [63:0] mosi_rx  = '0;

   radio_ctrl_top dut (.*);

   initial bus_clk = 1'b0;
   always #10 bus_clk = ~bus_clk;  // 50 MHz

   always @(posedge bus_clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT) begin
         $display("timeout: run did not finish within %0d bus clocks", CYCLE_LIMIT);
         $display("RESULT: FAIL");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Codec SPI slave, mode 0
   ////////////////////////////////////////////////////////////////////////////
   always @(negedge cat_sclk or posedge cat_ce) begin
      if (cat_ce) fall_cnt <= 0;  // Idle, MSB ready for next select
      else        fall_cnt <= fall_cnt + 1;
   end

   assign cat_miso = (!cat_ce && fall_cnt < 24) ? MISO_PATTERN[23 - fall_cnt] : 1'b0;

   always @(posedge cat_sclk) begin
      mosi_rx  <= {mosi_rx[62:0], cat_mosi};  // Host bits, newest at LSB
      rise_cnt <= rise_cnt + 1;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////////////////////
   task automatic next_cycle();
      @(posedge bus_clk);
      #1;  // Drive and sample just past the edge
   endtask

   task automatic report_mismatch(input string what, input logic [31:0] expected,
                                  input logic [31:0] actual);
      error_count++;
      $display("mismatch %s %s: expected %h, actual %h", cur_test, what, expected, actual);
   endtask

   task automatic report_error(input string msg);
      error_count++;
      $display("%s: %s", cur_test, msg);
   endtask

   task automatic start_test(input string name);
      cur_test          = name;
      test_start_errors = error_count;
   endtask

   task automatic finish_test();
      test_count++;
      if (error_count == test_start_errors) $display("test %s: ok", cur_test);
      else $display("test %s: %0d errors", cur_test, error_count - test_start_errors);
   endtask

   function automatic radio_ctrl_pkg::ctrl_word_u reg_word(input radio_ctrl_pkg::ctrl_op_e op,
                                                           input logic [7:0] addr,
                                                           input logic [31:0] data);
      radio_ctrl_pkg::ctrl_word_u w;
      w            = '0;
      w.reg_v.op   = op;
      w.reg_v.addr = addr;
      w.reg_v.data = data;
      return w;
   endfunction

   function automatic radio_ctrl_pkg::ctrl_word_u spi_word(input logic [2:0] slave,
                                                           input logic [5:0] nbits,
                                                           input logic [31:0] payload);
      radio_ctrl_pkg::ctrl_word_u w;
      w               = '0;
      w.spi_v.op      = radio_ctrl_pkg::OP_SPI;
      w.spi_v.slave   = slave;
      w.spi_v.nbits   = nbits;
      w.spi_v.payload = payload;
      return w;
   endfunction

   // Readback value from the register map
   function automatic logic [31:0] expected_reg(input logic [7:0] addr);
      if (addr < 8'd4) return shadow[addr[1:0]];
      if (addr == `RC_ADDR_STATUS) return 32'd1;  // Locked, SPI idle
      return 32'd0;
   endfunction

   task automatic send_word(input radio_ctrl_pkg::ctrl_word_u word);
      ctrl_word  = word;
      ctrl_valid = 1'b1;
      next_cycle();
      ctrl_valid = 1'b0;
   endtask

   task automatic wait_response(input int max_cycles, output logic got, output int waited,
                                output radio_ctrl_pkg::resp_t resp);
      got    = 1'b0;
      waited = 0;
      resp   = '0;
      while (!got && waited < max_cycles) begin
         next_cycle();
         waited++;
         if (resp_valid) begin
            got  = 1'b1;
            resp = resp_word;
         end
      end
   endtask

   task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
      send_word(reg_word(radio_ctrl_pkg::OP_WRITE, addr, data));
      if (addr < 8'd4) shadow[addr[1:0]] = data;  // Status and holes ignore writes
   endtask

   task automatic read_expect(input logic [7:0] addr, input logic [31:0] expected);
      logic                  got;
      int                    waited;
      radio_ctrl_pkg::resp_t resp;
      send_word(reg_word(radio_ctrl_pkg::OP_READ, addr, 32'd0));
      wait_response(4, got, waited, resp);
      if (!got) begin
         report_error($sformatf("no response to readback of address %0d", addr));
      end else begin
         if (waited != 1) report_mismatch("readback latency", 32'd1, 32'(waited));
         if (resp.kind !== radio_ctrl_pkg::OP_READ)
            report_mismatch("response kind", 32'(radio_ctrl_pkg::OP_READ), 32'(resp.kind));
         if (resp.tag !== addr) report_mismatch("response address", 32'(addr), 32'(resp.tag));
         if (resp.data !== expected) report_mismatch("readback data", expected, resp.data);
      end
   endtask

   `include "radio_ctrl_tests.svh"

   ////////////////////////////////////////////////////////////////////////////
   // Run sequence
   ////////////////////////////////////////////////////////////////////////////
   initial begin
      void'($urandom(88756));
      reset_global = 1'b1;
      pll_locked   = 1'b1;
      ctrl_valid   = 1'b0;
      ctrl_word    = '0;
      for (int i = 0; i < 4; i++) shadow[i] = 32'd0;
      shadow[3] = `RC_SPI_DIV_RESET;
      repeat (2) @(posedge bus_clk);
      #1;
      reset_global = 1'b0;

      holdoff_test();
      readback_test();
      atr_swap_test();
      misc_field_test();
      spi_transfer_test();
      random_write_test();

      $display("tests run %0d, errors %0d", test_count, error_count);
      if (error_count == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

// ==== tb.f ====
+incdir+source
+incdir+tests
source/radio_ctrl_pkg.sv
source/clocks_ready_holdoff.sv
source/ctrl_word_decode.sv
source/settings_regs.sv
source/spi_shift_engine.sv
source/frontend_pin_map.sv
source/ctrl_response.sv
source/radio_ctrl_top.sv
tests/radio_ctrl_tb.sv

// ==== Makefile ====
# Verilator build and run of the radio control testbench

SRCS := tb.f $(wildcard source/*.sv source/*.svh tests/*.sv tests/*.svh)

.PHONY: run clean

run: obj_dir/Vradio_ctrl_tb
	@out=$$(./obj_dir/Vradio_ctrl_tb); echo "$$out"; echo "$$out" | grep -qx 'RESULT: PASS'

obj_dir/Vradio_ctrl_tb: $(SRCS)
	verilator --binary --timing --timescale 1ns/10ps -f tb.f --top-module radio_ctrl_tb

clean:
	rm -rf obj_dir
